// ==== rtl/card_pkg.sv ====
package card_pkg;

   localparam int GRID_DIM  = 4;
   localparam int NUM_CARDS = GRID_DIM * GRID_DIM;

   // card number is four times the row plus the column
   typedef logic [3:0] card_idx_t;
   typedef logic [2:0] card_color_t;

   typedef enum logic [2:0] {
      PAL_RED     = 3'd0,
      PAL_GREEN   = 3'd1,
      PAL_BLUE    = 3'd2,
      PAL_YELLOW  = 3'd3,
      PAL_MAGENTA = 3'd4,
      PAL_CYAN    = 3'd5,
      PAL_GREY    = 3'd6,
      PAL_ORANGE  = 3'd7
   } palette_e;

   typedef enum logic {
      DEALING,
      DEALT
   } deal_state_e;

   // packed as red, green, blue with 8 bits each
   function automatic logic [23:0] palette_rgb(palette_e c);
      case (c)
         PAL_RED:     return {8'd200, 8'd0,   8'd0};
         PAL_GREEN:   return {8'd0,   8'd200, 8'd0};
         PAL_BLUE:    return {8'd0,   8'd0,   8'd200};
         PAL_YELLOW:  return {8'd200, 8'd200, 8'd0};
         PAL_MAGENTA: return {8'd200, 8'd0,   8'd200};
         PAL_CYAN:    return {8'd0,   8'd200, 8'd200};
         PAL_GREY:    return {8'd180, 8'd180, 8'd180};
         PAL_ORANGE:  return {8'd255, 8'd102, 8'd0};
         default:     return 24'd0;
      endcase
   endfunction

endpackage

// ==== rtl/screen_pkg.sv ====
package screen_pkg;

   // raster counter widths as the video timing block delivers them
   typedef logic [11:0] hcount_t;
   typedef logic [10:0] vcount_t;

   // offset inside one card, wide enough for the card size
   typedef logic [6:0] offset_t;

   typedef logic [7:0] rgb_t;

   // default layout of the 4 by 4 play field
   localparam int DEF_H_START   = 699;
   localparam int DEF_V_START   = 400;
   localparam int DEF_CARD_SIZE = 128;
   localparam int DEF_CARD_GAP  = 32;
   localparam int DEF_BORDER    = 8;

   localparam rgb_t COLOR_WHITE = 8'd255;

endpackage

// ==== rtl/raster_grid_decoder.sv ====
`timescale 1ns/1ps

module raster_grid_decoder
   import card_pkg::*;
   import screen_pkg::*;
#(
   parameter int H_START   = DEF_H_START,
   parameter int V_START   = DEF_V_START,
   parameter int CARD_SIZE = DEF_CARD_SIZE,
   parameter int CARD_GAP  = DEF_CARD_GAP
) (
   input  logic                     clk,
   input  logic                     reset,
   input  hcount_t                  hcnt,
   input  vcount_t                  vcnt,
   output logic    [GRID_DIM-1:0]   col_hit,
   output offset_t [GRID_DIM-1:0]   col_offset,
   output logic    [GRID_DIM-1:0]   row_hit,
   output offset_t [GRID_DIM-1:0]   row_offset
);

   localparam int PITCH = CARD_SIZE + CARD_GAP;

   hcount_t h_rel [GRID_DIM];
   vcount_t v_rel [GRID_DIM];

   // counts left of a span wrap around to large values, so one compare does
   always_comb
   begin
      for (int c = 0; c < GRID_DIM; c++)
      begin
         h_rel[c] = hcnt - hcount_t'(H_START + c * PITCH);
         v_rel[c] = vcnt - vcount_t'(V_START + c * PITCH);
      end
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         col_hit <= '0;
         row_hit <= '0;
      end
      else
      begin
         for (int c = 0; c < GRID_DIM; c++)
         begin
            col_hit[c] <= (h_rel[c] < CARD_SIZE);
            row_hit[c] <= (v_rel[c] < CARD_SIZE);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int c = 0; c < GRID_DIM; c++)
      begin
         col_offset[c] <= offset_t'(h_rel[c]); // only meaningful while the hit is set
         row_offset[c] <= offset_t'(v_rel[c]);
      end
   end

   // the gap between cards keeps the spans apart
   a_single_span : assert property (
      @(posedge clk) disable iff (!reset)
      $onehot0(col_hit) && $onehot0(row_hit)
   );

endmodule

// ==== rtl/card_tile.sv ====
`timescale 1ns/1ps

module card_tile
   import card_pkg::*;
   import screen_pkg::*;
#(
   parameter int CARD_SIZE = DEF_CARD_SIZE,
   parameter int BORDER    = DEF_BORDER,
   parameter int INDEX     = 0
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          col_hit,
   input  logic          row_hit,
   input  offset_t       col_offset,
   input  offset_t       row_offset,
   input  logic [3:0]    timer_tens,
   input  logic [3:0]    timer_ones,
   input  logic          flip,
   input  logic          key1,
   input  logic          key2,
   input  logic [1:0]    cursor_x,
   input  logic [1:0]    cursor_y,
   input  card_color_t   color,
   output logic          tile_hit,
   output logic          tile_lit,
   output card_color_t   tile_color
);

   localparam int MY_COL = INDEX % GRID_DIM;
   localparam int MY_ROW = INDEX / GRID_DIM;

   logic preview;
   logic key_here;
   logic face_up;
   logic face_up_q;
   logic in_face;

   // countdown digits are BCD, so below 05 means tens zero and ones under five
   assign preview = (timer_tens == 4'd0) && (timer_ones < 4'd5);

   assign key_here = (key1 || key2)
                     && (cursor_x == 2'(MY_COL))
                     && (cursor_y == 2'(MY_ROW));

   assign face_up = preview || flip || key_here;

   assign in_face = (col_offset >= BORDER) && (col_offset < CARD_SIZE - BORDER)
                    && (row_offset >= BORDER) && (row_offset < CARD_SIZE - BORDER);

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         face_up_q <= 1'b0;
         tile_hit  <= 1'b0;
         tile_lit  <= 1'b0;
      end
      else
      begin
         face_up_q <= face_up; // the controls wait one cycle to meet the registered offsets
         tile_hit  <= col_hit && row_hit;
         tile_lit  <= col_hit && row_hit && face_up_q && in_face; // border stays white
      end
   end

   // the deal is static once done, so the color needs no pipeline stage
   assign tile_color = color;

endmodule

// ==== rtl/deck_dealer.sv ====
`timescale 1ns/1ps

module deck_dealer
   import card_pkg::*;
(
   input  logic                           clk,
   input  logic                           reset,
   output card_color_t [NUM_CARDS-1:0]    card_colors
);

   deal_state_e state;
   card_idx_t   deal_cnt;
   logic [3:0]  lfsr;
   logic        feedback;
   logic        deal_we;

   assign feedback = lfsr[3] ^ lfsr[2];
   assign deal_we  = (state == DEALING);

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         state    <= DEALING;
         deal_cnt <= '0;
         lfsr     <= 4'hf; // all ones, the only seed the deal ever uses
      end
      else if (deal_we)
      begin
         deal_cnt <= deal_cnt + card_idx_t'(1);
         lfsr     <= {lfsr[2:0], feedback};
         if (deal_cnt == card_idx_t'(NUM_CARDS - 1))
         begin
            state <= DEALT;
         end
      end
   end

   // entries read as zero until the deal reaches them
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         card_colors <= '0;
      end
      else if (deal_we)
      begin
         card_colors[deal_cnt] <= lfsr[2:0];
      end
   end

   // once dealt the table never changes until the next reset
   a_deal_frozen : assert property (
      @(posedge clk) disable iff (!reset)
      (state == DEALT) |=> (state == DEALT) && $stable(card_colors)
   );

endmodule

// ==== rtl/pixel_mixer.sv ====
`timescale 1ns/1ps

module pixel_mixer
   import card_pkg::*;
   import screen_pkg::*;
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic        [NUM_CARDS-1:0]    tile_hit,
   input  logic        [NUM_CARDS-1:0]    tile_lit,
   input  card_color_t [NUM_CARDS-1:0]    tile_color,
   output rgb_t                           red,
   output rgb_t                           green,
   output rgb_t                           blue
);

   logic        any_hit;
   logic        hit_lit;
   card_color_t hit_color;
   logic [23:0] face_rgb;

   // at most one tile claims a pixel, so a plain scan is enough
   always_comb
   begin
      any_hit   = 1'b0;
      hit_lit   = 1'b0;
      hit_color = '0;
      for (int i = 0; i < NUM_CARDS; i++)
      begin
         if (tile_hit[i])
         begin
            any_hit   = 1'b1;
            hit_lit   = tile_lit[i];
            hit_color = tile_color[i];
         end
      end
   end

   assign face_rgb = palette_rgb(palette_e'(hit_color));

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         {red, green, blue} <= '0;
      end
      else if (!any_hit)
      begin
         {red, green, blue} <= '0; // gaps and the area around the grid
      end
      else if (hit_lit)
      begin
         {red, green, blue} <= face_rgb;
      end
      else
      begin
         {red, green, blue} <= {3{COLOR_WHITE}};
      end
   end

   // the decoder and the sixteen tiles together must never claim a pixel twice
   a_one_tile : assert property (
      @(posedge clk) disable iff (!reset)
      $onehot0(tile_hit)
   );

endmodule

// ==== rtl/card_table.sv ====
`timescale 1ns/1ps

module card_table
   import card_pkg::*;
   import screen_pkg::*;
#(
   parameter int H_START   = DEF_H_START,
   parameter int V_START   = DEF_V_START,
   parameter int CARD_SIZE = DEF_CARD_SIZE,
   parameter int CARD_GAP  = DEF_CARD_GAP,
   parameter int BORDER    = DEF_BORDER
) (
   input  logic                           clk,
   input  logic                           reset,
   input  hcount_t                        hcnt,
   input  vcount_t                        vcnt,
   input  logic        [3:0]              timer_tens,
   input  logic        [3:0]              timer_ones,
   input  logic                           key1,
   input  logic                           key2,
   input  logic        [1:0]              cursor_x,
   input  logic        [1:0]              cursor_y,
   input  logic        [NUM_CARDS-1:0]    flip,
   output rgb_t                           red,
   output rgb_t                           green,
   output rgb_t                           blue,
   output card_color_t [NUM_CARDS-1:0]    card_colors
);

   logic        [GRID_DIM-1:0]  col_hit;
   logic        [GRID_DIM-1:0]  row_hit;
   offset_t     [GRID_DIM-1:0]  col_offset;
   offset_t     [GRID_DIM-1:0]  row_offset;
   logic        [NUM_CARDS-1:0] tile_hit;
   logic        [NUM_CARDS-1:0] tile_lit;
   card_color_t [NUM_CARDS-1:0] tile_color;

   raster_grid_decoder #(
      .H_START   (H_START),
      .V_START   (V_START),
      .CARD_SIZE (CARD_SIZE),
      .CARD_GAP  (CARD_GAP)
   ) u_decoder (
      .clk        (clk),
      .reset      (reset),
      .hcnt       (hcnt),
      .vcnt       (vcnt),
      .col_hit    (col_hit),
      .col_offset (col_offset),
      .row_hit    (row_hit),
      .row_offset (row_offset)
   );

   deck_dealer u_dealer (
      .clk         (clk),
      .reset       (reset),
      .card_colors (card_colors)
   );

   // tile k sits in column k mod 4 and row k div 4
   for (genvar k = 0; k < NUM_CARDS; k++)
   begin : g_tile
      card_tile #(
         .CARD_SIZE (CARD_SIZE),
         .BORDER    (BORDER),
         .INDEX     (k)
      ) u_tile (
         .clk        (clk),
         .reset      (reset),
         .col_hit    (col_hit[k % GRID_DIM]),
         .row_hit    (row_hit[k / GRID_DIM]),
         .col_offset (col_offset[k % GRID_DIM]),
         .row_offset (row_offset[k / GRID_DIM]),
         .timer_tens (timer_tens),
         .timer_ones (timer_ones),
         .flip       (flip[k]),
         .key1       (key1),
         .key2       (key2),
         .cursor_x   (cursor_x),
         .cursor_y   (cursor_y),
         .color      (card_colors[k]),
         .tile_hit   (tile_hit[k]),
         .tile_lit   (tile_lit[k]),
         .tile_color (tile_color[k])
      );
   end

   pixel_mixer u_mixer (
      .clk        (clk),
      .reset      (reset),
      .tile_hit   (tile_hit),
      .tile_lit   (tile_lit),
      .tile_color (tile_color),
      .red        (red),
      .green      (green),
      .blue       (blue)
   );

endmodule

// ==== include/card_table_model.svh ====
`ifndef CARD_TABLE_MODEL_SVH
`define CARD_TABLE_MODEL_SVH

typedef enum {KIND_BLACK, KIND_WHITE, KIND_PALETTE} pixel_kind_e;

localparam int H_START   = 699;
localparam int V_START   = 400;
localparam int CARD_SIZE = 128;
localparam int CARD_GAP  = 32;
localparam int BORDER    = 8;
localparam int PITCH     = CARD_SIZE + CARD_GAP;

logic [2:0] dealt_colors [16];

// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// the deck LFSR starts at all ones and each card takes its low three bits
task automatic replay_deal();
   logic [3:0] s;
   s = 4'hf;
   for (int i = 0; i < 16; i++)
   begin
      dealt_colors[i] = s[2:0];
      s = {s[2:0], s[3] ^ s[2]};
   end
endtask

function automatic logic [23:0] palette_value(logic [2:0] idx);
   case (idx)
      3'd0:    return 24'hc80000;
      3'd1:    return 24'h00c800;
      3'd2:    return 24'h0000c8;
      3'd3:    return 24'hc8c800;
      3'd4:    return 24'hc800c8;
      3'd5:    return 24'h00c8c8;
      3'd6:    return 24'hb4b4b4;
      default: return 24'hff6600;
   endcase
endfunction

function automatic bit locate_card(input int h, input int v, output int card,
                                   output int hoff, output int voff);
   int col;
   int row;
   col  = -1;
   row  = -1;
   card = 0;
   hoff = 0;
   voff = 0;
   for (int c = 0; c < 4; c++)
   begin
      if (h >= H_START + c * PITCH && h < H_START + c * PITCH + CARD_SIZE)
      begin
         col  = c;
         hoff = h - H_START - c * PITCH;
      end
      if (v >= V_START + c * PITCH && v < V_START + c * PITCH + CARD_SIZE)
      begin
         row  = c;
         voff = v - V_START - c * PITCH;
      end
   end
   card = 4 * row + col;
   return (col >= 0) && (row >= 0);
endfunction

function automatic pixel_kind_e expected_kind(int h, int v, logic [7:0] timer,
                                              logic [15:0] flip, logic [1:0] keys,
                                              logic [1:0] cx, logic [1:0] cy);
   int  card;
   int  hoff;
   int  voff;
   bit  up;
   if (!locate_card(h, v, card, hoff, voff))
      return KIND_BLACK;
   up = (timer < 8'h05) || flip[card]
        || ((keys != 2'b00) && (int'(cx) == card % 4) && (int'(cy) == card / 4));
   if (up && hoff >= BORDER && hoff < CARD_SIZE - BORDER
          && voff >= BORDER && voff < CARD_SIZE - BORDER)
      return KIND_PALETTE;
   return KIND_WHITE; // face-down cards and every border are white
endfunction

function automatic logic [23:0] kind_rgb(pixel_kind_e kind, int h, int v);
   int card;
   int hoff;
   int voff;
   void'(locate_card(h, v, card, hoff, voff));
   case (kind)
      KIND_BLACK: return 24'h000000;
      KIND_WHITE: return 24'hffffff;
      default:    return palette_value(dealt_colors[card]);
   endcase
endfunction

task automatic check_value(string name, logic [23:0] expected, logic [23:0] actual);
   if (expected !== actual)
   begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
   end
endtask

`endif

// ==== test/card_table_tb.sv ====
`timescale 1ns/1ps

module card_table_tb;

`include "card_table_model.svh"

   typedef struct {
      string       name;
      int          h;
      int          v;
      logic [7:0]  timer;
      logic [15:0] flip;
      logic [1:0]  keys;
      logic [1:0]  cx;
      logic [1:0]  cy;
      pixel_kind_e kind;
   } pixel_row_t;

   localparam int         RESET_CYCLES = 4;
   localparam int         DEAL_WAIT    = 20;
   localparam int         PIPE_DEPTH   = 3; // depth of the pixel pipeline
   localparam logic [7:0] T_PREVIEW    = 8'h03;
   localparam logic [7:0] T_HIDDEN     = 8'h05;

   logic        clk = 1'b0;
   logic        reset;
   logic [11:0] hcnt;
   logic [10:0] vcnt;
   logic [3:0]  timer_tens;
   logic [3:0]  timer_ones;
   logic        key1;
   logic        key2;
   logic [1:0]  cursor_x;
   logic [1:0]  cursor_y;
   logic [15:0] flip;
   logic [7:0]  red;
   logic [7:0]  green;
   logic [7:0]  blue;
   logic [47:0] card_colors;

   pixel_row_t  rows [$];
   logic [31:0] rng_state = 32'hcffe;
   int          cycle_count = 0;
   int          cycle_limit;

   always #4 clk = ~clk;

   card_table #(.H_START(H_START), .V_START(V_START), .CARD_SIZE(CARD_SIZE),
                .CARD_GAP(CARD_GAP), .BORDER(BORDER)) i_dut (
      .clk(clk), .reset(reset), .hcnt(hcnt), .vcnt(vcnt),
      .timer_tens(timer_tens), .timer_ones(timer_ones), .key1(key1), .key2(key2),
      .cursor_x(cursor_x), .cursor_y(cursor_y), .flip(flip),
      .red(red), .green(green), .blue(blue), .card_colors(card_colors)
   );

   function automatic int center_h(int card);
      return H_START + (card % 4) * PITCH + CARD_SIZE / 2;
   endfunction

   function automatic int center_v(int card);
      return V_START + (card / 4) * PITCH + CARD_SIZE / 2;
   endfunction

   function automatic logic [31:0] random_bits(int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         rng_state = lfsr_step(rng_state);
         val = {val[30:0], rng_state[0]};
      end
      return val;
   endfunction

   task automatic add_row(string name, int h, int v, logic [7:0] timer, logic [15:0] flp,
                          logic [1:0] keys, logic [1:0] cx, logic [1:0] cy, pixel_kind_e kind);
      pixel_row_t r;
      r = '{name, h, v, timer, flp, keys, cx, cy, kind};
      rows.push_back(r);
   endtask

   task automatic build_table();
      logic [31:0] fl;
      logic [31:0] cur;
      logic [31:0] k1;
      logic [31:0] pick;
      int          c;
      for (int k = 0; k < 16; k++)
      begin
         add_row($sformatf("preview_center_%0d", k), center_h(k), center_v(k), T_PREVIEW,
                 16'h0, 2'b00, 2'd0, 2'd0, KIND_PALETTE);
         add_row($sformatf("hidden_center_%0d", k), center_h(k), center_v(k), T_HIDDEN,
                 16'h0, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      end
      add_row("preview_border_0", H_START + 2, center_v(0), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      add_row("preview_border_10", center_h(10), V_START + 2 * PITCH + CARD_SIZE - 3, T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      add_row("timer_12_center_5", center_h(5), center_v(5), 8'h12,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      add_row("flip_own_6", center_h(6), center_v(6), 8'h09,
              16'h0040, 2'b00, 2'd0, 2'd0, KIND_PALETTE);
      add_row("flip_other_7", center_h(7), center_v(7), 8'h09,
              16'h0040, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      add_row("key1_cursor_9", center_h(9), center_v(9), T_HIDDEN,
              16'h0, 2'b01, 2'd1, 2'd2, KIND_PALETTE);
      add_row("key1_other_8", center_h(8), center_v(8), T_HIDDEN,
              16'h0, 2'b01, 2'd1, 2'd2, KIND_WHITE);
      add_row("key1_other_13", center_h(13), center_v(13), T_HIDDEN,
              16'h0, 2'b01, 2'd1, 2'd2, KIND_WHITE);
      add_row("key2_cursor_3", center_h(3), center_v(3), T_HIDDEN,
              16'h0, 2'b10, 2'd3, 2'd0, KIND_PALETTE);
      add_row("no_key_cursor_3", center_h(3), center_v(3), T_HIDDEN,
              16'h0, 2'b00, 2'd3, 2'd0, KIND_WHITE);
      add_row("gap_column", H_START + CARD_SIZE + 10, center_v(0), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_BLACK);
      add_row("gap_row", center_h(0), V_START + CARD_SIZE + 5, T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_BLACK);
      add_row("outside_left", 10, center_v(4), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_BLACK);
      add_row("outside_right", H_START + 3 * PITCH + CARD_SIZE + 20, center_v(7), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_BLACK);
      add_row("outside_below", center_h(12), V_START + 3 * PITCH + CARD_SIZE, T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_BLACK);
      add_row("span_first_0", H_START, center_v(0), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      add_row("span_last_0", H_START + CARD_SIZE - 1, center_v(0), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      add_row("span_before_0", H_START - 1, center_v(0), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_BLACK);
      add_row("span_last_row_12", center_h(12), V_START + 3 * PITCH + CARD_SIZE - 1, T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_WHITE);
      add_row("face_first_0", H_START + BORDER, center_v(0), T_PREVIEW,
              16'h0, 2'b00, 2'd0, 2'd0, KIND_PALETTE);
      add_row("face_last_15", H_START + 3 * PITCH + CARD_SIZE - BORDER - 1, center_v(15),
              T_PREVIEW, 16'h0, 2'b00, 2'd0, 2'd0, KIND_PALETTE);
      // random flips and cursor moves, judged by the geometric model
      for (int n = 0; n < 24; n++)
      begin
         fl   = random_bits(16);
         cur  = random_bits(4);
         k1   = random_bits(1);
         pick = random_bits(4);
         c    = int'(pick[3:0]);
         add_row($sformatf("random_%0d", n), center_h(c), center_v(c), 8'h06, fl[15:0],
                 {1'b0, k1[0]}, cur[1:0], cur[3:2],
                 expected_kind(center_h(c), center_v(c), 8'h06, fl[15:0], {1'b0, k1[0]},
                               cur[1:0], cur[3:2]));
      end
   endtask

   task automatic drive_row(pixel_row_t r);
      hcnt       = 12'(r.h);
      vcnt       = 11'(r.v);
      timer_tens = r.timer[7:4];
      timer_ones = r.timer[3:0];
      flip       = r.flip;
      {key2, key1} = r.keys;
      cursor_x   = r.cx;
      cursor_y   = r.cy;
   endtask

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: the run went past %0d clock cycles", cycle_limit);
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   initial
   begin
      pixel_row_t  done_row;
      logic [23:0] expected;
      reset      = 1'b0;
      hcnt       = '0;
      vcnt       = '0;
      timer_tens = 4'd9;
      timer_ones = 4'd9;
      key1       = 1'b0;
      key2       = 1'b0;
      cursor_x   = 2'd0;
      cursor_y   = 2'd0;
      flip       = '0;
      replay_deal();
      build_table();
      cycle_limit = rows.size() + 40;
      repeat (RESET_CYCLES) @(negedge clk);
      check_value("reset_rgb", 24'h0, {red, green, blue});
      check_value("reset_deal", 24'h0, card_colors[23:0] | card_colors[47:24]);
      reset = 1'b1;
      repeat (DEAL_WAIT) @(negedge clk);
      for (int k = 0; k < 16; k++)
         check_value($sformatf("deal_%0d", k), {21'd0, dealt_colors[k]},
                     {21'd0, card_colors[3 * k +: 3]});
      // one row enters per cycle and leaves the pipeline PIPE_DEPTH cycles later
      for (int j = 0; j < rows.size() + PIPE_DEPTH; j++)
      begin
         if (j >= PIPE_DEPTH)
         begin
            done_row = rows[j - PIPE_DEPTH];
            expected = kind_rgb(done_row.kind, done_row.h, done_row.v);
            check_value(done_row.name, expected, {red, green, blue});
         end
         if (j < rows.size())
            drive_row(rows[j]);
         @(negedge clk);
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== card_table.f ====
+incdir+include
rtl/card_pkg.sv
rtl/screen_pkg.sv
rtl/raster_grid_decoder.sv
rtl/card_tile.sv
rtl/deck_dealer.sv
rtl/pixel_mixer.sv
rtl/card_table.sv
test/card_table_tb.sv

// ==== Bender.yml ====
package:
  name: card_table

sources:
  - files:
      - rtl/card_pkg.sv
      - rtl/screen_pkg.sv
      - rtl/raster_grid_decoder.sv
      - rtl/card_tile.sv
      - rtl/deck_dealer.sv
      - rtl/pixel_mixer.sv
      - rtl/card_table.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/card_table_tb.sv
